// File: verilog/csrPkg.sv
//////////////////////////////////////////////////////////////////////
// shared CSR addresses, op codes, mode codes and the status word views
// referenced by scoped name from the CSR unit and its testbench
//////////////////////////////////////////////////////////////////////

package csrPkg;

  // CSR addresses handled by the status block
  localparam logic [11:0] addrSstatus  = 12'h100;
  localparam logic [11:0] addrMstatus  = 12'h300;
  localparam logic [11:0] addrMisa     = 12'h301;
  localparam logic [11:0] addrMstatush = 12'h310;

  // privilege modes, 2'b10 is reserved
  localparam logic [1:0] modeU = 2'b00;
  localparam logic [1:0] modeS = 2'b01;
  localparam logic [1:0] modeM = 2'b11;

  // csr op, low two bits of funct3
  localparam logic [1:0] opWrite = 2'b01; // csrrw
  localparam logic [1:0] opSet   = 2'b10; // csrrs
  localparam logic [1:0] opClear = 2'b11; // csrrc

  //////////////////////////////////////////////////////////////////////
  // status word layouts, RV32
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       sd;       // 31
    logic [7:0] wpri30;   // 30:23 reserved
    logic       tsr;      // 22
    logic       tw;       // 21
    logic       tvm;      // 20
    logic       mxr;      // 19
    logic       sum;      // 18
    logic       mprv;     // 17
    logic [1:0] xs;       // 16:15
    logic [1:0] fs;       // 14:13
    logic [1:0] mpp;      // 12:11
    logic [1:0] wpri10;   // 10:9
    logic       spp;      // 8
    logic       mpie;     // 7
    logic       ube;      // 6
    logic       spie;     // 5
    logic       wpri4;
    logic       mie;      // 3
    logic       wpri2;
    logic       sie;      // 1
    logic       wpri0;
  } mstatusFields_t;

  typedef struct packed {
    logic [23:0] wpri31;  // 31:8 reserved
    logic        mpv;     // 7, hypervisor only
    logic        gva;     // 6, hypervisor only
    logic        mbe;     // 5
    logic        sbe;     // 4
    logic [3:0]  wpri3;   // 3:0
  } mstatushFields_t;

  // one 32-bit word, decoded as low or high status half
  typedef union packed {
    logic [31:0]     raw;
    mstatusFields_t  mstatus;
    mstatushFields_t mstatush;
  } statusWord_u;

endpackage

// File: verilog/csrDecode.sv
//////////////////////////////////////////////////////////////////////
// CSR instruction decode: legality, write strobes and merged value
//////////////////////////////////////////////////////////////////////

module csrDecode #(
  parameter bit sSupported = 1'b1
) (
  input  logic        csrEn,
  input  logic [1:0]  csrOp,
  input  logic [11:0] csrAddr,
  input  logic [31:0] csrSrc,
  input  logic [1:0]  privMode,
  input  logic [31:0] readData,     // old value, from the read mux
  output logic [31:0] writeValue,
  output logic        writeMstatus,
  output logic        writeMstatush,
  output logic        writeSstatus,
  output logic        illegal
);

  logic isMstatus, isMstatush, isSstatus, isMisa;
  logic addrKnown;
  logic privFault;    // addr needs more privilege than we have
  logic readOnly;
  logic doesWrite;    // instruction modifies the csr
  logic legalWrite;

  //////////////////////////////////////////////////////////////////////
  // address checks
  //////////////////////////////////////////////////////////////////////

  assign isMstatus  = (csrAddr == csrPkg::addrMstatus);
  assign isMstatush = (csrAddr == csrPkg::addrMstatush);
  assign isMisa     = (csrAddr == csrPkg::addrMisa);
  assign isSstatus  = sSupported & (csrAddr == csrPkg::addrSstatus); // gone without S

  assign addrKnown = isMstatus | isMstatush | isMisa | isSstatus;
  assign privFault = (csrAddr[9:8] > privMode);          // bits 9:8 hold min privilege
  assign readOnly  = (csrAddr[11:10] == 2'b11) | isMisa; // misa is fixed here

  // set and clear with a zero source are plain reads
  always_comb begin
    case (csrOp)
      csrPkg::opWrite: doesWrite = 1'b1;
      csrPkg::opSet,
      csrPkg::opClear: doesWrite = |csrSrc;
      default:         doesWrite = 1'b0;
    endcase
  end

  assign illegal = csrEn & (~addrKnown | privFault | (readOnly & doesWrite));

  //////////////////////////////////////////////////////////////////////
  // merge and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csrOp)
      csrPkg::opWrite: writeValue = csrSrc;
      csrPkg::opSet:   writeValue = readData | csrSrc;
      csrPkg::opClear: writeValue = readData & ~csrSrc;
      default:         writeValue = readData; // no change
    endcase
  end

  assign legalWrite = csrEn & doesWrite & ~illegal;

  // address compares are exclusive, so at most one strobe
  assign writeMstatus  = legalWrite & isMstatus;
  assign writeMstatush = legalWrite & isMstatush;
  assign writeSstatus  = legalWrite & isSstatus;

endmodule

// File: verilog/privMode.sv
//////////////////////////////////////////////////////////////////////
// current privilege mode and the next-mode choice on traps and returns
//////////////////////////////////////////////////////////////////////

module privMode #(
  parameter bit sSupported = 1'b1
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  logic       trap,
  input  logic       trapToSuper,   // delegation says take it in S
  input  logic       mret,
  input  logic       sret,
  input  logic [1:0] statusMpp,
  input  logic       statusSpp,
  output logic [1:0] nextPrivMode,  // shared with status bookkeeping
  output logic [1:0] privMode
);

  logic [1:0] trapMode;

  // delegation never lowers privilege out of M
  assign trapMode = (trapToSuper & sSupported & (privMode != csrPkg::modeM)) ?
                    csrPkg::modeS : csrPkg::modeM;

  // same priority as the status register: trap, mret, sret
  always_comb begin
    if (trap)
      nextPrivMode = trapMode;
    else if (mret)
      nextPrivMode = statusMpp;          // mpp is kept legal by WARL
    else if (sret & sSupported)
      nextPrivMode = {1'b0, statusSpp}; // spp 1 is S, 0 is U
    else
      nextPrivMode = privMode;
  end

  always_ff @(posedge clk) begin
    if (reset)
      privMode <= csrPkg::modeM;     // boot in machine mode
    else if (~stall)
      privMode <= nextPrivMode;
  end

endmodule

// File: verilog/statusReg.sv
//////////////////////////////////////////////////////////////////////
// mstatus / mstatush field registers with WARL rules and read views
// also drives the status control bits and the data endianness
//////////////////////////////////////////////////////////////////////

module statusReg #(
  parameter bit sSupported         = 1'b1,
  parameter bit uSupported         = 1'b1,
  parameter bit fSupported         = 1'b1,
  parameter bit bigEndianSupported = 1'b1,
  parameter bit virtMemSupported   = 1'b1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,
  input  logic        trap,
  input  logic [1:0]  nextPrivMode,
  input  logic [1:0]  privMode,
  input  logic        mret,
  input  logic        sret,
  input  logic        fpWrite,        // fp register or fcsr update
  input  logic        writeMstatus,
  input  logic        writeMstatush,
  input  logic        writeSstatus,
  input  logic [31:0] writeValue,
  output logic [31:0] mstatusWord,
  output logic [31:0] sstatusWord,
  output logic [31:0] mstatushWord,
  output logic [1:0]  statusMpp,
  output logic        statusSpp,
  output logic        statusMie,
  output logic        statusSie,
  output logic        statusTsr,
  output logic        statusTw,
  output logic        statusTvm,
  output logic        statusMxr,
  output logic        statusSum,
  output logic        statusMprv,
  output logic [1:0]  statusFs,
  output logic        bigEndian
);

  csrPkg::statusWord_u wv;           // incoming write word
  csrPkg::statusWord_u mView, sView, hView;
  logic       mpie, spie;
  logic       mbe, sbe, ube;
  logic [1:0] mppNext;
  logic [1:0] endianMode;
  logic       endianBit;
  logic       sd;

  assign wv.raw = writeValue;
  assign sd     = (statusFs == 2'b11); // xs is always zero

  // mpp is WARL, reserved or unsupported modes keep the old value
  always_comb begin
    if (wv.mstatus.mpp == csrPkg::modeU && uSupported)
      mppNext = csrPkg::modeU;
    else if (wv.mstatus.mpp == csrPkg::modeS && sSupported)
      mppNext = csrPkg::modeS;
    else if (wv.mstatus.mpp == csrPkg::modeM)
      mppNext = csrPkg::modeM;
    else
      mppNext = statusMpp;
  end

  //////////////////////////////////////////////////////////////////////
  // field registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      statusTsr  <= 1'b0;
      statusTw   <= 1'b0;
      statusTvm  <= 1'b0;
      statusMxr  <= 1'b0;
      statusSum  <= 1'b0;
      statusMprv <= 1'b0;
      statusFs   <= 2'b00;   // fp off until enabled
      statusMpp  <= 2'b00;
      statusSpp  <= 1'b0;
      mpie       <= 1'b0;
      spie       <= 1'b0;
      statusMie  <= 1'b0;
      statusSie  <= 1'b0;
      mbe        <= 1'b0;
      sbe        <= 1'b0;
      ube        <= 1'b0;
    end else if (~stall) begin
      if (trap) begin
        if (nextPrivMode == csrPkg::modeM) begin
          mpie      <= statusMie;  // stack the enable
          statusMie <= 1'b0;
          statusMpp <= privMode;
        end else if (sSupported) begin  // delegated to S
          spie      <= statusSie;
          statusSie <= 1'b0;
          statusSpp <= privMode[0];
        end
      end else if (mret) begin
        statusMie  <= mpie;
        mpie       <= 1'b1;
        statusMpp  <= uSupported ? csrPkg::modeU : csrPkg::modeM; // lowest mode
        statusMprv <= statusMprv & (statusMpp == csrPkg::modeM);  // leaving M drops mprv
      end else if (sret & sSupported) begin
        statusSie  <= spie;
        spie       <= 1'b1;
        statusSpp  <= 1'b0;
        statusMprv <= 1'b0;   // sret never returns to M
      end else if (writeMstatus) begin
        statusTsr  <= sSupported & wv.mstatus.tsr;
        statusTw   <= uSupported & wv.mstatus.tw;
        statusTvm  <= sSupported & wv.mstatus.tvm;
        statusMxr  <= sSupported & wv.mstatus.mxr;
        statusSum  <= sSupported & virtMemSupported & wv.mstatus.sum;
        statusMprv <= uSupported & wv.mstatus.mprv;
        statusFs   <= fSupported ? wv.mstatus.fs : 2'b00;
        statusMpp  <= mppNext;
        statusSpp  <= sSupported & wv.mstatus.spp;
        mpie       <= wv.mstatus.mpie;
        spie       <= sSupported & wv.mstatus.spie;
        statusMie  <= wv.mstatus.mie;
        statusSie  <= sSupported & wv.mstatus.sie;
        ube        <= uSupported & bigEndianSupported & wv.mstatus.ube;
      end else if (writeMstatush) begin
        mbe <= bigEndianSupported & wv.mstatush.mbe;   // mpv, gva hardwired zero
        sbe <= sSupported & bigEndianSupported & wv.mstatush.sbe;
      end else if (writeSstatus) begin  // supervisor subset only
        statusMxr <= sSupported & wv.mstatus.mxr;
        statusSum <= sSupported & virtMemSupported & wv.mstatus.sum;
        statusFs  <= fSupported ? wv.mstatus.fs : 2'b00;
        statusSpp <= sSupported & wv.mstatus.spp;
        spie      <= sSupported & wv.mstatus.spie;
        statusSie <= sSupported & wv.mstatus.sie;
        ube       <= uSupported & bigEndianSupported & wv.mstatus.ube;
      end else if (fpWrite & fSupported) begin
        statusFs <= 2'b11;   // dirty
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read views
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mView.raw           = '0;
    mView.mstatus.sd    = sd;
    mView.mstatus.tsr   = statusTsr;
    mView.mstatus.tw    = statusTw;
    mView.mstatus.tvm   = statusTvm;
    mView.mstatus.mxr   = statusMxr;
    mView.mstatus.sum   = statusSum;
    mView.mstatus.mprv  = statusMprv;
    mView.mstatus.fs    = statusFs;
    mView.mstatus.mpp   = statusMpp;
    mView.mstatus.spp   = statusSpp;
    mView.mstatus.mpie  = mpie;
    mView.mstatus.ube   = ube;
    mView.mstatus.spie  = spie;
    mView.mstatus.mie   = statusMie;
    mView.mstatus.sie   = statusSie;
    // sstatus shows the supervisor subset
    sView.raw           = '0;
    sView.mstatus.sd    = sd;
    sView.mstatus.mxr   = statusMxr;
    sView.mstatus.sum   = statusSum;
    sView.mstatus.fs    = statusFs;
    sView.mstatus.spp   = statusSpp;
    sView.mstatus.ube   = ube;
    sView.mstatus.spie  = spie;
    sView.mstatus.sie   = statusSie;
    hView.raw           = '0;
    hView.mstatush.mbe  = mbe;
    hView.mstatush.sbe  = sbe;
  end

  assign mstatusWord  = mView.raw;
  assign sstatusWord  = sView.raw;
  assign mstatushWord = hView.raw;

  // endianness follows mpp when M-mode accesses run with mprv
  assign endianMode = (privMode == csrPkg::modeM && statusMprv) ? statusMpp : privMode;

  always_comb begin
    case (endianMode)
      csrPkg::modeM: endianBit = mbe;
      csrPkg::modeS: endianBit = sbe;
      default:       endianBit = ube;
    endcase
  end

  assign bigEndian = bigEndianSupported & endianBit;

endmodule

// File: verilog/csrReadMux.sv
//////////////////////////////////////////////////////////////////////
// CSR read select by address, with misa built from the parameters
//////////////////////////////////////////////////////////////////////

module csrReadMux #(
  parameter bit sSupported = 1'b1,
  parameter bit uSupported = 1'b1,
  parameter bit fSupported = 1'b1
) (
  input  logic [11:0] csrAddr,
  input  logic [31:0] mstatusWord,
  input  logic [31:0] sstatusWord,
  input  logic [31:0] mstatushWord,
  output logic [31:0] readData
);

  logic [31:0] misaWord;

  // misa letters are bit (letter - 'A')
  always_comb begin
    misaWord        = '0;
    misaWord[31:30] = 2'b01;       // mxl = 32 bit
    misaWord[8]     = 1'b1;        // I
    misaWord[12]    = 1'b1;        // M
    misaWord[5]     = fSupported;  // F
    misaWord[18]    = sSupported;  // S
    misaWord[20]    = uSupported;  // U
  end

  always_comb begin
    case (csrAddr)
      csrPkg::addrMstatus:  readData = mstatusWord;
      csrPkg::addrSstatus:  readData = sstatusWord;
      csrPkg::addrMstatush: readData = mstatushWord;
      csrPkg::addrMisa:     readData = misaWord;
      default:              readData = '0;   // unknown csr
    endcase
  end

endmodule

// File: verilog/csrUnit.sv
//////////////////////////////////////////////////////////////////////
// status part of the CSR unit, sets the feature parameters
//////////////////////////////////////////////////////////////////////

module csrUnit #(
  parameter bit sSupported         = 1'b1,  // needs uSupported
  parameter bit uSupported         = 1'b1,
  parameter bit fSupported         = 1'b1,
  parameter bit bigEndianSupported = 1'b1,
  parameter bit virtMemSupported   = 1'b1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,
  input  logic        csrEn,
  input  logic [1:0]  csrOp,
  input  logic [11:0] csrAddr,
  input  logic [31:0] csrSrc,
  input  logic        trap,
  input  logic        trapToSuper,
  input  logic        mret,
  input  logic        sret,
  input  logic        fpWrite,
  output logic [31:0] csrReadData,
  output logic        illegal,
  output logic [1:0]  privMode,
  output logic        statusMie,
  output logic        statusSie,
  output logic        statusTsr,
  output logic        statusTw,
  output logic        statusTvm,
  output logic        statusMxr,
  output logic        statusSum,
  output logic        statusMprv,
  output logic [1:0]  statusFs,
  output logic        bigEndian
);

  logic [31:0] writeValue;
  logic        writeMstatus, writeMstatush, writeSstatus;
  logic [31:0] mstatusWord, sstatusWord, mstatushWord;
  logic [1:0]  statusMpp;
  logic        statusSpp;
  logic [1:0]  nextPrivMode;

  csrDecode #(.sSupported(sSupported)) csrDecode_i (
    .csrEn, .csrOp, .csrAddr, .csrSrc, .privMode,
    .readData(csrReadData),       // old value for set / clear
    .writeValue, .writeMstatus, .writeMstatush, .writeSstatus, .illegal
  );

  privMode #(.sSupported(sSupported)) privMode_i (
    .clk, .reset, .stall, .trap, .trapToSuper, .mret, .sret,
    .statusMpp, .statusSpp, .nextPrivMode, .privMode
  );

  statusReg #(
    .sSupported(sSupported), .uSupported(uSupported), .fSupported(fSupported),
    .bigEndianSupported(bigEndianSupported), .virtMemSupported(virtMemSupported)
  ) statusReg_i (
    .clk, .reset, .stall, .trap, .nextPrivMode, .privMode, .mret, .sret, .fpWrite,
    .writeMstatus, .writeMstatush, .writeSstatus, .writeValue,
    .mstatusWord, .sstatusWord, .mstatushWord, .statusMpp, .statusSpp,
    .statusMie, .statusSie, .statusTsr, .statusTw, .statusTvm, .statusMxr,
    .statusSum, .statusMprv, .statusFs, .bigEndian
  );

  csrReadMux #(
    .sSupported(sSupported), .uSupported(uSupported), .fSupported(fSupported)
  ) csrReadMux_i (
    .csrAddr, .mstatusWord, .sstatusWord, .mstatushWord,
    .readData(csrReadData)
  );

endmodule

// File: verif/csrUnitTb.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the CSR status unit, drives on the falling edge
// clock, reset, lfsr source, compare tasks and tests, run from the Makefile
//////////////////////////////////////////////////////////////////////

module csrUnitTb;

  localparam int cycleLimit = 12 + 56 + 16 + 16 + 22 + 26 + 64; // test lengths plus margin

  logic        clk, reset, stall;
  logic        csrEn;
  logic [1:0]  csrOp;
  logic [11:0] csrAddr;
  logic [31:0] csrSrc;
  logic        trap, trapToSuper, mret, sret, fpWrite;
  logic [31:0] csrReadData;
  logic        illegal;
  logic [1:0]  privMode;
  logic        statusMie, statusSie, statusTsr, statusTw, statusTvm;
  logic        statusMxr, statusSum, statusMprv;
  logic [1:0]  statusFs;
  logic        bigEndian;
  logic [31:0] lfsr;          // random source state
  int          checks, errors;
  int          cycles = 0;

  csrUnit csrUnit_i (
    .clk, .reset, .stall, .csrEn, .csrOp, .csrAddr, .csrSrc,
    .trap, .trapToSuper, .mret, .sret, .fpWrite,
    .csrReadData, .illegal, .privMode,
    .statusMie, .statusSie, .statusTsr, .statusTw, .statusTvm,
    .statusMxr, .statusSum, .statusMprv, .statusFs, .bigEndian
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // expected values and random source
  //////////////////////////////////////////////////////////////////////

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic randomWord(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsrStep(lfsr);  // one step per bit
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  // with all features on every standard mstatus field is writable
  function automatic csrPkg::statusWord_u maskMstatus(input logic [31:0] word,
                                                      input logic [1:0]  oldMpp);
    csrPkg::statusWord_u w, m;
    w.raw          = word;
    m.raw          = '0;
    m.mstatus.tsr  = w.mstatus.tsr;
    m.mstatus.tw   = w.mstatus.tw;
    m.mstatus.tvm  = w.mstatus.tvm;
    m.mstatus.mxr  = w.mstatus.mxr;
    m.mstatus.sum  = w.mstatus.sum;
    m.mstatus.mprv = w.mstatus.mprv;
    m.mstatus.fs   = w.mstatus.fs;
    m.mstatus.mpp  = (w.mstatus.mpp == 2'b10) ? oldMpp : w.mstatus.mpp; // reserved mode
    m.mstatus.spp  = w.mstatus.spp;
    m.mstatus.mpie = w.mstatus.mpie;
    m.mstatus.ube  = w.mstatus.ube;
    m.mstatus.spie = w.mstatus.spie;
    m.mstatus.mie  = w.mstatus.mie;
    m.mstatus.sie  = w.mstatus.sie;
    m.mstatus.sd   = (m.mstatus.fs == 2'b11);  // xs stays zero
    return m;
  endfunction

  // supervisor subset of a full mstatus word
  function automatic logic [31:0] sstatusView(input csrPkg::statusWord_u m);
    csrPkg::statusWord_u s;
    s.raw          = '0;
    s.mstatus.sd   = m.mstatus.sd;
    s.mstatus.mxr  = m.mstatus.mxr;
    s.mstatus.sum  = m.mstatus.sum;
    s.mstatus.fs   = m.mstatus.fs;
    s.mstatus.spp  = m.mstatus.spp;
    s.mstatus.ube  = m.mstatus.ube;
    s.mstatus.spie = m.mstatus.spie;
    s.mstatus.sie  = m.mstatus.sie;
    return s.raw;
  endfunction

  function automatic logic [31:0] misaExpected();
    logic [31:0] w;
    w        = '0;
    w[31:30] = 2'b01;  // 32 bit
    w[5]     = 1'b1;   // F
    w[8]     = 1'b1;   // I
    w[12]    = 1'b1;   // M
    w[18]    = 1'b1;   // S
    w[20]    = 1'b1;   // U
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks and drivers
  //////////////////////////////////////////////////////////////////////

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkMode(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // control outputs against the fields of a model mstatus word
  task automatic checkControl(input csrPkg::statusWord_u m);
    checkBit("statusTsr", statusTsr, m.mstatus.tsr);
    checkBit("statusTw", statusTw, m.mstatus.tw);
    checkBit("statusTvm", statusTvm, m.mstatus.tvm);
    checkBit("statusMxr", statusMxr, m.mstatus.mxr);
    checkBit("statusSum", statusSum, m.mstatus.sum);
    checkBit("statusMprv", statusMprv, m.mstatus.mprv);
    checkBit("statusMie", statusMie, m.mstatus.mie);
    checkBit("statusSie", statusSie, m.mstatus.sie);
    checkMode("statusFs", statusFs, m.mstatus.fs);
  endtask

  task automatic drive(input logic en, input logic [1:0] op, input logic [11:0] addr,
                       input logic [31:0] src);
    @(negedge clk);
    csrEn       = en;
    csrOp       = op;
    csrAddr     = addr;
    csrSrc      = src;
    trap        = 1'b0;
    trapToSuper = 1'b0;
    mret        = 1'b0;
    sret        = 1'b0;
    fpWrite     = 1'b0;
    #2;  // read path settles well before the rising edge
  endtask

  task automatic applyEvent(input logic t, input logic toSuper, input logic m,
                            input logic s, input logic f);
    @(negedge clk);
    csrEn       = 1'b0;
    trap        = t;
    trapToSuper = toSuper;
    mret        = m;
    sret        = s;
    fpWrite     = f;
    #2;
  endtask

  task automatic idle();
    drive(1'b0, csrPkg::opWrite, 12'h000, 32'h0);
  endtask

  // set with zero source is a plain read
  task automatic readCsr(input logic [11:0] addr, output logic [31:0] data);
    drive(1'b1, csrPkg::opSet, addr, 32'h0);
    data = csrReadData;
  endtask

  task automatic setStall(input logic value);
    @(negedge clk);
    stall = value;
  endtask

  // trap to M from any mode then load mstatus and mret to the mode in w
  task automatic enterUser(input logic [31:0] w);
    applyEvent(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w);
    applyEvent(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic testReset();
    logic [31:0] data;
    readCsr(csrPkg::addrMstatus, data);
    checkWord("mstatus", data, 32'h0);
    readCsr(csrPkg::addrSstatus, data);
    checkWord("sstatus", data, 32'h0);
    readCsr(csrPkg::addrMstatush, data);
    checkWord("mstatush", data, 32'h0);
    readCsr(csrPkg::addrMisa, data);
    checkWord("misa", data, misaExpected());
    checkMode("privMode", privMode, csrPkg::modeM);
    checkBit("statusMie", statusMie, 1'b0);
    checkBit("statusSie", statusSie, 1'b0);
    checkBit("statusTsr", statusTsr, 1'b0);
    checkBit("statusTw", statusTw, 1'b0);
    checkBit("statusTvm", statusTvm, 1'b0);
    checkBit("statusMxr", statusMxr, 1'b0);
    checkBit("statusSum", statusSum, 1'b0);
    checkBit("statusMprv", statusMprv, 1'b0);
    checkBit("bigEndian", bigEndian, 1'b0);
    checkMode("statusFs", statusFs, 2'b00);   // fp off
    checkBit("illegal", illegal, 1'b0);
  endtask

  task automatic testWriteMask();
    csrPkg::statusWord_u model, got;
    logic [31:0] w, data;
    logic [1:0]  oldMpp;
    model.raw = '0;
    for (int n = 0; n < 8; n++) begin
      randomWord(w);
      drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w);
      model = maskMstatus(w, model.mstatus.mpp);
      readCsr(csrPkg::addrMstatus, data);
      checkWord("mstatus", data, model.raw);
      checkControl(model);
      readCsr(csrPkg::addrSstatus, data);
      checkWord("sstatus", data, sstatusView(model));
    end
    // reserved mpp keeps the old value
    randomWord(w);
    w[12:11] = 2'b10;
    oldMpp   = model.mstatus.mpp;
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w);
    model = maskMstatus(w, oldMpp);
    readCsr(csrPkg::addrMstatus, data);
    got.raw = data;
    checkMode("mstatus.mpp", got.mstatus.mpp, oldMpp);
    checkWord("mstatus", data, model.raw);
    for (int n = 0; n < 3; n++) begin
      randomWord(w);
      drive(1'b1, csrPkg::opSet, csrPkg::addrMstatus, w);
      model = maskMstatus(model.raw | w, model.mstatus.mpp);
      readCsr(csrPkg::addrMstatus, data);
      checkWord("mstatus after set", data, model.raw);
      randomWord(w);
      drive(1'b1, csrPkg::opClear, csrPkg::addrMstatus, w);
      model = maskMstatus(model.raw & ~w, model.mstatus.mpp);
      readCsr(csrPkg::addrMstatus, data);
      checkWord("mstatus after clear", data, model.raw);
    end
    // a zero set raises no strobe and lets a same-cycle fpWrite land
    drive(1'b1, csrPkg::opClear, csrPkg::addrMstatus, 32'h0000_6000);  // fs off
    model = maskMstatus(model.raw & ~32'h0000_6000, model.mstatus.mpp);
    drive(1'b1, csrPkg::opSet, csrPkg::addrMstatus, 32'h0);
    fpWrite = 1'b1;           // same cycle as the zero set
    checkBit("illegal", illegal, 1'b0);
    readCsr(csrPkg::addrMstatus, data);
    model.mstatus.fs = 2'b11;
    model.mstatus.sd = 1'b1;
    checkWord("mstatus after zero set", data, model.raw);
  endtask

  task automatic testTrapMret();
    csrPkg::statusWord_u w, exp;
    logic [31:0] data;
    w.raw          = '0;
    w.mstatus.mpie = 1'b1;
    w.mstatus.mpp  = csrPkg::modeU;
    enterUser(w.raw);                 // lands in U with mie set
    idle();
    checkMode("privMode", privMode, csrPkg::modeU);
    checkBit("statusMie", statusMie, 1'b1);
    applyEvent(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    readCsr(csrPkg::addrMstatus, data);
    checkMode("privMode", privMode, csrPkg::modeM);
    exp.raw          = '0;
    exp.mstatus.mpie = 1'b1;          // old mie
    exp.mstatus.mpp  = csrPkg::modeU;
    checkWord("mstatus after trap", data, exp.raw);
    checkBit("statusMie", statusMie, 1'b0);
    // mret back into M takes mie from mpie and sets mpp to U
    w.raw          = '0;
    w.mstatus.mpp  = csrPkg::modeM;
    w.mstatus.mie  = 1'b1;
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w.raw);
    applyEvent(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    readCsr(csrPkg::addrMstatus, data);
    checkMode("privMode", privMode, csrPkg::modeM);
    exp.raw          = '0;
    exp.mstatus.mpie = 1'b1;
    exp.mstatus.mpp  = csrPkg::modeU;
    checkWord("mstatus after mret", data, exp.raw);
  endtask

  task automatic testDelegSret();
    csrPkg::statusWord_u w, exp;
    logic [31:0] data;
    w.raw         = '0;
    w.mstatus.sie = 1'b1;
    w.mstatus.mpp = csrPkg::modeU;
    enterUser(w.raw);
    applyEvent(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);   // delegated
    readCsr(csrPkg::addrSstatus, data);
    checkMode("privMode", privMode, csrPkg::modeS);
    checkBit("illegal", illegal, 1'b0);
    exp.raw          = '0;
    exp.mstatus.spie = 1'b1;        // old sie with spp still U
    checkWord("sstatus after trap", data, exp.raw);
    checkBit("statusSie", statusSie, 1'b0);
    applyEvent(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    idle();
    checkMode("privMode", privMode, csrPkg::modeU);
    checkBit("statusSie", statusSie, 1'b1);
    checkBit("statusMprv", statusMprv, 1'b0);
    applyEvent(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    readCsr(csrPkg::addrSstatus, data);
    exp.mstatus.sie = 1'b1;
    checkWord("sstatus after sret", data, exp.raw);
  endtask

  task automatic testIllegalStall();
    csrPkg::statusWord_u w;
    logic [31:0] data, r;
    enterUser(32'h0);
    readCsr(csrPkg::addrMstatus, data);
    checkBit("illegal mstatus from U", illegal, 1'b1);
    applyEvent(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    randomWord(r);
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMisa, r);
    checkBit("illegal misa write", illegal, 1'b1);
    readCsr(csrPkg::addrMisa, data);
    checkBit("illegal misa read", illegal, 1'b0);
    checkWord("misa", data, misaExpected());
    readCsr(csrPkg::addrMstatus, data);
    checkWord("mstatus", data, 32'h0);
    // stalled write and trap must not land
    w.raw         = '0;
    w.mstatus.mie = 1'b1;
    w.mstatus.mpp = csrPkg::modeM;
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w.raw);
    setStall(1'b1);
    randomWord(r);
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, r);
    applyEvent(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    readCsr(csrPkg::addrMstatus, data);
    checkWord("mstatus in stall", data, w.raw);
    setStall(1'b0);
    readCsr(csrPkg::addrMstatus, data);
    checkWord("mstatus after stall", data, w.raw);
    checkMode("privMode", privMode, csrPkg::modeM);
  endtask

  task automatic testFpEndian();
    csrPkg::statusWord_u w, exp;
    logic [31:0] data;
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, 32'h0);
    applyEvent(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    readCsr(csrPkg::addrMstatus, data);
    exp.raw        = '0;
    exp.mstatus.fs = 2'b11;   // dirty
    exp.mstatus.sd = 1'b1;
    checkWord("mstatus after fpWrite", data, exp.raw);
    checkBit("statusFs dirty", &statusFs, 1'b1);
    exp.raw          = '0;
    exp.mstatush.mbe = 1'b1;
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatush, exp.raw);
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, 32'h0);  // mpp U and ube off
    readCsr(csrPkg::addrMstatush, data);
    checkWord("mstatush", data, exp.raw);
    checkBit("bigEndian in M", bigEndian, 1'b1);
    applyEvent(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    idle();
    checkMode("privMode", privMode, csrPkg::modeU);
    checkBit("bigEndian in U", bigEndian, 1'b0);
    applyEvent(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    idle();
    checkBit("bigEndian in M", bigEndian, 1'b1);
    w.raw          = '0;
    w.mstatus.ube  = 1'b1;
    w.mstatus.mprv = 1'b1;    // M accesses act as U
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatush, 32'h0);
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w.raw);
    idle();
    checkMode("privMode", privMode, csrPkg::modeM);
    checkBit("bigEndian with mprv", bigEndian, 1'b1);
    w.mstatus.mprv = 1'b0;
    drive(1'b1, csrPkg::opWrite, csrPkg::addrMstatus, w.raw);
    idle();
    checkBit("bigEndian in M", bigEndian, 1'b0);
    applyEvent(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    idle();
    checkBit("bigEndian in U", bigEndian, 1'b1);
  endtask

  initial begin
    reset       = 1'b1;
    stall       = 1'b0;
    csrEn       = 1'b0;
    csrOp       = csrPkg::opWrite;
    csrAddr     = 12'h000;
    csrSrc      = 32'h0;
    trap        = 1'b0;
    trapToSuper = 1'b0;
    mret        = 1'b0;
    sret        = 1'b0;
    fpWrite     = 1'b0;
    lfsr        = 32'hb3de;
    checks      = 0;
    errors      = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    testReset();
    testWriteMask();
    testTrapMret();
    testDelegSret();
    testIllegalStall();
    testFpEndian();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: project.f
verilog/csrPkg.sv
verilog/csrDecode.sv
verilog/privMode.sv
verilog/statusReg.sv
verilog/csrReadMux.sv
verilog/csrUnit.sv
verif/csrUnitTb.sv

// File: Makefile
# Verilator build and run for the CSR status unit testbench

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= csrUnitTb
DUT_TOP   ?= csrUnit
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# pass only when the simulation prints the pass line
run: build
	@out="$$($(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
